// ==== src/crc_params.svh ====
/*
 * Register word offsets, register reset values
 * and buffer depth of the AHB CRC unit
 */
`ifndef CRC_PARAMS_SVH
`define CRC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

// Word offsets as seen on HADDR[4:2]
`define CRC_DR_OFS    3'd0
`define CRC_IDR_OFS   3'd1
`define CRC_CR_OFS    3'd2
`define CRC_INIT_OFS  3'd4
`define CRC_POL_OFS   3'd5

// Reset value of CRC_INIT and of the CRC register
`define CRC_INIT_RST  32'hFFFF_FFFF
// Reset polynomial is the Ethernet CRC-32
`define CRC_POLY_RST  32'h04C1_1DB7

// Entries held by the write buffer
`define CRC_BUF_DEPTH 2

`endif

// ==== src/crc_pkg.sv ====
/*
 * Shared types of the AHB CRC unit
 * Bus words, bytes, config codes and the sequencer states
 */
package crc_pkg;

	// Bus data, CRC value, polynomial and initial value
	typedef logic [31:0] word_t;

	// One byte on its way to the CRC engine
	typedef logic [7:0] byte_t;

	// Polynomial width code
	// 00 is 32 bits, 01 is 16, 10 is 8, 11 is 7
	typedef logic [1:0] poly_size_t;

	// Input reversal code
	// 00 none, 01 per byte, 10 per halfword, 11 whole word
	typedef logic [1:0] rev_in_t;

	// Transfer size from HSIZE
	// 0 byte, 1 halfword, 2 word
	typedef logic [1:0] bus_size_t;

	// Sequencer states
	typedef enum logic [1:0]
	{
		CTRL_IDLE = 2'd0,
		CTRL_FEED = 2'd1,
		CTRL_LOAD = 2'd2
	} ctrl_state_t;

endpackage

// ==== src/crc_cfg_if.sv ====
/*
 * Configuration bundle from the register block to the datapath
 */
interface crc_cfg_if
	import crc_pkg::*;
();

	// Polynomial width select
	poly_size_t poly_size;
	// Input bit reversal mode
	rev_in_t    rev_in;
	// Output bit reversal enable
	logic       rev_out;
	// Programmed polynomial and seed
	word_t      crc_poly;
	word_t      crc_init;

	// Register block drives everything
	modport source (output poly_size, rev_in, rev_out, crc_poly, crc_init);

	// Datapath blocks only look
	modport sink (input poly_size, rev_in, rev_out, crc_poly, crc_init);

endinterface

// ==== src/host_interface.sv ====
/*
 * AHB-Lite slave of the CRC unit
 * Address phase pipeline, register decode, stall logic,
 * CR, IDR, INIT and POL registers and the read mux
 */
`include "crc_params.svh"

module host_interface
	import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSELx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	input  logic        buffer_full,
	input  logic        read_wait,
	input  logic        reset_pending,
	input  word_t       crc_out,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	output logic        buffer_write_en,
	output logic        reset_chain,
	output word_t       bus_wr,
	output bus_size_t   bus_size,
	crc_cfg_if.source   cfg
);

	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic       HRESP_OKAY    = 1'b0;

	// Registered address phase
	logic [2:0] haddr_pp;
	bus_size_t  hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	// Software visible registers
	logic [4:0] cr_q;
	byte_t      idr_q;
	word_t      init_q;
	word_t      poly_q;

	logic sample_bus;
	logic ahb_enable;
	logic write_en;
	logic read_en;
	logic dr_sel;
	logic idr_sel;
	logic cr_sel;
	logic init_sel;
	logic pol_sel;
	logic dr_req;
	logic dr_rd;
	logic init_req;
	logic idr_wr;
	logic cr_wr;
	logic init_wr;
	logic pol_wr;

	////////////////////////////////////////////////////////////////////////////
	// Address phase
	////////////////////////////////////////////////////////////////////////////

	// Next address is taken only when the current data phase completes
	assign sample_bus = HREADY && HREADYOUT;

	// Select and transfer type decide whether a data phase is ours
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= 2'b00;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSELx;
			htrans_pp <= HTRANS;
		end
	end

	// Address, size and direction of the held transfer
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
		end
	end

	// SEQ beats are not acted on
	assign ahb_enable = hselx_pp && (htrans_pp == HTRANS_NONSEQ);
	assign write_en   = ahb_enable && hwrite_pp;
	assign read_en    = ahb_enable && !hwrite_pp;

	// Register decode
	assign dr_sel   = (haddr_pp == `CRC_DR_OFS);
	assign idr_sel  = (haddr_pp == `CRC_IDR_OFS);
	assign cr_sel   = (haddr_pp == `CRC_CR_OFS);
	assign init_sel = (haddr_pp == `CRC_INIT_OFS);
	assign pol_sel  = (haddr_pp == `CRC_POL_OFS);

	assign dr_req   = dr_sel && write_en;
	assign dr_rd    = dr_sel && read_en;
	assign init_req = init_sel && write_en;

	////////////////////////////////////////////////////////////////////////////
	// Stall and write strobes
	////////////////////////////////////////////////////////////////////////////

	// DR write waits for room, DR read for a settled CRC
	// INIT write waits until a pending chain reset has used the old seed
	assign HREADYOUT = !((dr_req && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_req && reset_pending));

	// Never an error
	assign HRESP = HRESP_OKAY;

	// Strobes only on the completing cycle
	assign buffer_write_en = dr_req && !buffer_full;
	assign init_wr         = init_req && !reset_pending;
	assign idr_wr          = idr_sel && write_en;
	assign cr_wr           = cr_sel && write_en;
	assign pol_wr          = pol_sel && write_en;

	// CR bit 0 is a self clearing reset request
	assign reset_chain = cr_wr && HWDATA[0];

	// Write data comes straight from the bus in the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			cr_q   <= 5'd0;
			idr_q  <= 8'd0;
			init_q <= `CRC_INIT_RST;
			poly_q <= `CRC_POLY_RST;
		end
		else
		begin
			// rev_out, rev_in and poly size live in CR[7:3]
			if (cr_wr)
				cr_q <= HWDATA[7:3];
			if (idr_wr)
				idr_q <= HWDATA[7:0];
			if (init_wr)
				init_q <= HWDATA;
			if (pol_wr)
				poly_q <= HWDATA;
		end
	end

	// Config out to the datapath
	assign cfg.poly_size = cr_q[1:0];
	assign cfg.rev_in    = cr_q[3:2];
	assign cfg.rev_out   = cr_q[4];
	assign cfg.crc_poly  = poly_q;
	assign cfg.crc_init  = init_q;

	// Read mux on the held address
	always_comb
	begin
		case (haddr_pp)
			`CRC_DR_OFS:   HRDATA = crc_out;
			`CRC_IDR_OFS:  HRDATA = {24'd0, idr_q};
			`CRC_CR_OFS:   HRDATA = {24'd0, cr_q, 3'b000};
			`CRC_INIT_OFS: HRDATA = init_q;
			`CRC_POL_OFS:  HRDATA = poly_q;
			default:       HRDATA = 32'd0;
		endcase
	end

	// A data phase opened without a selected NONSEQ transfer never stalls
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(sample_bus && !(HSELx && HTRANS == HTRANS_NONSEQ)) |=> HREADYOUT);

	// Register strobes come from a registered write, on its completing cycle only
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(buffer_write_en || idr_wr || cr_wr || init_wr || pol_wr) |->
		write_en && HREADYOUT);

endmodule

// ==== src/data_buffer.sv ====
/*
 * Two entry buffer of DR writes
 * Applies input bit reversal and hands out bytes lowest first
 */
`include "crc_params.svh"

module data_buffer
	import crc_pkg::*;
(
	input  logic      HCLK,
	input  logic      HRESETn,
	input  logic      buffer_write_en,
	input  logic      byte_take,
	input  word_t     bus_wr,
	input  bus_size_t bus_size,
	crc_cfg_if.sink   cfg,
	output logic      buffer_full,
	output logic      byte_valid,
	output byte_t     byte_data,
	output logic      buffer_empty
);

	localparam int DEPTH = `CRC_BUF_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Entry payload and index of its last byte
	word_t      entry_data [DEPTH];
	logic [1:0] entry_last [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   fill;
	logic [1:0]       byte_idx;
	logic [1:0]       size_span;
	logic [1:0]       span_code;
	logic [1:0]       wr_last;
	logic             retire;
	word_t            wr_rev;
	word_t            head_word;

	// Mirror bits inside lanes of 8, 16 or 32 bits
	function automatic word_t reverse_span(word_t d, logic [1:0] code);
		word_t      r;
		logic [4:0] flip;
		case (code)
			2'd1:    flip = 5'd7;
			2'd2:    flip = 5'd15;
			2'd3:    flip = 5'd31;
			default: flip = 5'd0;
		endcase
		for (int i = 0; i < 32; i++)
			r[i] = d[5'(i) ^ flip];
		return r;
	endfunction

	// A reversal never reaches past the bytes actually written
	assign size_span = bus_size + 2'd1;
	assign span_code = (cfg.rev_in > size_span) ? size_span : cfg.rev_in;
	assign wr_rev    = reverse_span(bus_wr, span_code);

	// Last byte index from the transfer size
	always_comb
	begin
		case (bus_size)
			2'd0:    wr_last = 2'd0;
			2'd1:    wr_last = 2'd1;
			default: wr_last = 2'd3;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			entry_data[wr_ptr] <= wr_rev;
			entry_last[wr_ptr] <= wr_last;
		end
	end

	// Head entry drops out with its last byte
	assign retire = byte_take && (byte_idx == entry_last[rd_ptr]);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill     <= '0;
			byte_idx <= 2'd0;
		end
		else
		begin
			if (buffer_write_en)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (retire)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Write and retire in one cycle leave the fill level alone
			if (buffer_write_en && !retire)
				fill <= fill + 1'b1;
			else if (retire && !buffer_write_en)
				fill <= fill - 1'b1;
			if (retire)
				byte_idx <= 2'd0;
			else if (byte_take)
				byte_idx <= byte_idx + 2'd1;
		end
	end

	assign buffer_full  = (fill == (PTR_W + 1)'(DEPTH));
	assign buffer_empty = (fill == '0);
	assign byte_valid   = !buffer_empty;

	// Current byte of the head entry
	assign head_word = entry_data[rd_ptr];
	assign byte_data = head_word[{byte_idx, 3'b000} +: 8];

	// Host side must hold off while full
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

	assert property (@(posedge HCLK) disable iff (!HRESETn)
		byte_take |-> byte_valid);

endmodule

// ==== src/crc_compute.sv ====
/*
 * Byte wide CRC engine
 * Width select, seed load and output bit reversal
 */
`include "crc_params.svh"

module crc_compute
	import crc_pkg::*;
(
	input  logic    HCLK,
	input  logic    HRESETn,
	input  logic    fold_en,
	input  logic    load_init,
	input  byte_t   fold_byte,
	crc_cfg_if.sink cfg,
	output word_t   crc_out
);

	word_t      crc_q;
	word_t      next_crc;
	word_t      rev_crc;
	word_t      width_mask;
	logic [4:0] top_bit;
	logic [4:0] out_shift;

	// Eight shift steps, data MSB first
	function automatic word_t fold8(word_t crc, byte_t data, word_t poly, logic [4:0] top);
		word_t c;
		logic  fb;
		c = crc;
		for (int i = 7; i >= 0; i--)
		begin
			// Feedback taken from the top bit of the active width
			fb = c[top] ^ data[i];
			c  = {c[30:0], 1'b0};
			if (fb)
				c = c ^ poly;
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Width decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (cfg.poly_size)
			2'b00:
			begin
				width_mask = 32'hFFFF_FFFF;
				top_bit    = 5'd31;
				out_shift  = 5'd0;
			end
			2'b01:
			begin
				width_mask = 32'h0000_FFFF;
				top_bit    = 5'd15;
				out_shift  = 5'd16;
			end
			2'b10:
			begin
				width_mask = 32'h0000_00FF;
				top_bit    = 5'd7;
				out_shift  = 5'd24;
			end
			default:
			begin
				width_mask = 32'h0000_007F;
				top_bit    = 5'd6;
				out_shift  = 5'd25;
			end
		endcase
	end

	// Junk above the width is shifted in but masked off here
	assign next_crc = fold8(crc_q, fold_byte, cfg.crc_poly, top_bit) & width_mask;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_q <= `CRC_INIT_RST;
		else if (load_init)
			crc_q <= cfg.crc_init & width_mask;
		else if (fold_en)
			crc_q <= next_crc;
	end

	// Full word mirror then shift down to the active width
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			rev_crc[i] = crc_q[31 - i];
	end

	// Width changes without a reload may leave stale upper bits in the register
	assign crc_out = cfg.rev_out ? (rev_crc >> out_shift) : (crc_q & width_mask);

	// Sequencer keeps load and fold apart
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(fold_en && load_init));

endmodule

// ==== src/crc_control.sv ====
/*
 * Sequencer of the CRC unit
 * Byte feed FSM, chain reset handling, stall conditions
 */
module crc_control
	import crc_pkg::*;
(
	input  logic  HCLK,
	input  logic  HRESETn,
	input  logic  reset_chain,
	input  logic  byte_valid,
	input  logic  buffer_empty,
	input  byte_t byte_data,
	output logic  byte_take,
	output logic  fold_en,
	output logic  load_init,
	output logic  read_wait,
	output logic  reset_pending,
	output byte_t fold_byte
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	// Latched chain reset request
	logic reset_req;

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			CTRL_IDLE:
			begin
				// Buffered bytes go before a pending reload
				if (byte_valid)
					state_nxt = CTRL_FEED;
				else if (reset_req && buffer_empty && !fold_en)
					state_nxt = CTRL_LOAD;
			end
			CTRL_FEED:
			begin
				if (!byte_valid)
					state_nxt = CTRL_IDLE;
			end
			CTRL_LOAD:
				state_nxt = CTRL_IDLE;
			default:
				state_nxt = CTRL_IDLE;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			state <= CTRL_IDLE;
		else
			state <= state_nxt;
	end

	// One byte per cycle while feeding
	assign byte_take = (state == CTRL_FEED) && byte_valid;
	assign load_init = (state == CTRL_LOAD);

	// Fold stage one cycle behind the take
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			fold_en <= 1'b0;
		else
			fold_en <= byte_take;
	end

	always_ff @(posedge HCLK)
	begin
		if (byte_take)
			fold_byte <= byte_data;
	end

	// Request held until the load cycle
	// a new request in that cycle survives it
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			reset_req <= 1'b0;
		else if (reset_chain)
			reset_req <= 1'b1;
		else if (load_init)
			reset_req <= 1'b0;
	end

	assign reset_pending = reset_req;

	// CRC is final only when nothing is buffered, moving or pending
	assign read_wait = !buffer_empty || (state != CTRL_IDLE) || reset_req;

	// A reload always answers a latched chain reset request
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		load_init |-> reset_req);

endmodule

// ==== src/crc_ahb_top.sv ====
/*
 * Top level of the AHB CRC unit
 * Bus slave, write buffer, sequencer and CRC engine
 */
module crc_ahb_top
	import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSELx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	// Host to buffer
	logic      buffer_write_en;
	logic      buffer_full;
	word_t     bus_wr;
	bus_size_t bus_size;

	// Buffer to sequencer
	logic  byte_valid;
	logic  buffer_empty;
	logic  byte_take;
	byte_t byte_data;

	// Sequencer to engine and host
	logic  fold_en;
	logic  load_init;
	byte_t fold_byte;
	logic  read_wait;
	logic  reset_pending;
	logic  reset_chain;
	word_t crc_out;

	// Register settings shared by the datapath
	crc_cfg_if u_cfg ();

	host_interface u_host (
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSELx           (HSELx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.buffer_full     (buffer_full),
		.read_wait       (read_wait),
		.reset_pending   (reset_pending),
		.crc_out         (crc_out),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.buffer_write_en (buffer_write_en),
		.reset_chain     (reset_chain),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.cfg             (u_cfg.source)
	);

	data_buffer u_buffer (
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.buffer_write_en (buffer_write_en),
		.byte_take       (byte_take),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.cfg             (u_cfg.sink),
		.buffer_full     (buffer_full),
		.byte_valid      (byte_valid),
		.byte_data       (byte_data),
		.buffer_empty    (buffer_empty)
	);

	crc_control u_control (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.reset_chain   (reset_chain),
		.byte_valid    (byte_valid),
		.buffer_empty  (buffer_empty),
		.byte_data     (byte_data),
		.byte_take     (byte_take),
		.fold_en       (fold_en),
		.load_init     (load_init),
		.read_wait     (read_wait),
		.reset_pending (reset_pending),
		.fold_byte     (fold_byte)
	);

	crc_compute u_compute (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.fold_en   (fold_en),
		.load_init (load_init),
		.fold_byte (fold_byte),
		.cfg       (u_cfg.sink),
		.crc_out   (crc_out)
	);

endmodule

// ==== tb/tb_crc_ahb.sv ====
/*
 * Testbench of the AHB CRC unit
 * AHB driver tasks, reference CRC model, LFSR stimulus,
 * bus assertions, watchdog and the closing report
 */
`include "crc_params.svh"

module tb_crc_ahb
	import crc_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 10;
	// Reset checks, default CRC, widths, reversal, burst, chain reset
	localparam int PLANNED_XFERS = 6 + 17 + 60 + 80 + 10 + 12;
	localparam int WATCHDOG_NS = (PLANNED_XFERS * 200 + 8) * CLK_PERIOD;
	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	logic        HCLK;
	logic        HRESETn;
	logic        HSELx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Reference model state
	word_t      model_crc;
	poly_size_t cfg_psize;
	rev_in_t    cfg_rev_in;
	logic       cfg_rev_out;
	word_t      cfg_poly;
	word_t      cfg_init;

	word_t wr_data [16];
	word_t lfsr_q;
	word_t rd_val;
	word_t new_init;
	word_t cr_val;
	word_t rnd;
	int    errors;
	int    checks;
	int    stall_cnt;

	crc_ahb_top u_dut (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSELx     (HSELx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	// Single slave on the bus
	assign HREADY = HREADYOUT;

	initial
	begin
		HCLK = 1'b0;
		forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, one step per bit handed out
	function automatic word_t rand_bits(input int n);
		word_t r;
		logic  fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			// Taps 32, 22, 2, 1
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r      = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic int width_of(input poly_size_t code);
		case (code)
			2'b00:   return 32;
			2'b01:   return 16;
			2'b10:   return 8;
			default: return 7;
		endcase
	endfunction

	function automatic word_t mask_of(input int w);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
	endfunction

	// Mirror every lane of the given bit count
	function automatic word_t mirror_lanes(input word_t d, input int lane);
		word_t r;
		int    base;
		r = '0;
		for (int i = 0; i < 32; i++)
		begin
			base = (i / lane) * lane;
			r[base + lane - 1 - (i - base)] = d[i];
		end
		return r;
	endfunction

	// Textbook bitwise CRC step, data MSB first
	function automatic word_t fold_ref(input word_t crc, input byte_t b,
	                                   input word_t poly, input int w);
		word_t m;
		logic  fb;
		m = mask_of(w);
		for (int i = 7; i >= 0; i--)
		begin
			fb  = crc[w - 1] ^ b[i];
			crc = (crc << 1) & m;
			if (fb)
				crc = crc ^ (poly & m);
		end
		return crc;
	endfunction

	// Value a DR read should return now
	function automatic word_t expected_dr();
		int    w;
		word_t r;
		w = width_of(cfg_psize);
		if (!cfg_rev_out)
			return model_crc;
		r = '0;
		for (int i = 0; i < w; i++)
			r[w - 1 - i] = model_crc[i];
		return r;
	endfunction

	// Reversal reaches at most over the bytes written, then bytes go lowest first
	task automatic model_write(input word_t data, input logic [1:0] size);
		int    code;
		int    nbytes;
		word_t w;
		nbytes = 1 << size;
		code   = int'(cfg_rev_in);
		if (code > int'(size) + 1)
			code = int'(size) + 1;
		w = (code == 0) ? data : mirror_lanes(data, 4 << code);
		for (int b = 0; b < nbytes; b++)
			model_crc = fold_ref(model_crc, w[8 * b +: 8], cfg_poly, width_of(cfg_psize));
	endtask

	task automatic expect_equal(input string what, input word_t got, input word_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// AHB driver
	////////////////////////////////////////////////////////////////////////////

	// Look at the bus mid cycle, then move on to the next rising edge
	task automatic step_cycle(output logic ready, output word_t rdata);
		@(negedge HCLK);
		ready = HREADYOUT;
		rdata = HRDATA;
		@(posedge HCLK);
	endtask

	task automatic drive_addr(input logic [2:0] ofs, input logic [1:0] size, input logic wr);
		HSELx  <= 1'b1;
		HADDR  <= {27'd0, ofs, 2'b00};
		HTRANS <= HTRANS_NONSEQ;
		HSIZE  <= {1'b0, size};
		HWRITE <= wr;
	endtask

	task automatic drive_idle();
		HSELx  <= 1'b0;
		HTRANS <= HTRANS_IDLE;
		HWRITE <= 1'b0;
	endtask

	// Pipelined writes of wr_data[0..n-1], next address overlaps the data phase
	task automatic write_burst(input logic [2:0] ofs, input logic [1:0] size, input int n);
		int    k;
		logic  ready;
		word_t rd;
		@(posedge HCLK);
		drive_addr(ofs, size, 1'b1);
		k = 0;
		while (k <= n)
		begin
			step_cycle(ready, rd);
			if (ready)
			begin
				k++;
				if (k <= n)
					HWDATA <= wr_data[k - 1];
				if (k < n)
					drive_addr(ofs, size, 1'b1);
				else
					drive_idle();
			end
			else
				stall_cnt++;
		end
	endtask

	task automatic bus_read(input logic [2:0] ofs, output word_t data);
		int    k;
		logic  ready;
		word_t rd;
		@(posedge HCLK);
		drive_addr(ofs, 2'd2, 1'b0);
		k = 0;
		while (k < 2)
		begin
			step_cycle(ready, rd);
			if (ready)
			begin
				k++;
				if (k == 1)
					drive_idle();
				else
					data = rd;
			end
		end
	endtask

	// Register write that keeps the model config in step
	task automatic reg_write(input logic [2:0] ofs, input word_t value);
		wr_data[0] = value;
		write_burst(ofs, 2'd2, 1);
		case (ofs)
			`CRC_CR_OFS:
			begin
				cfg_psize   = value[4:3];
				cfg_rev_in  = value[6:5];
				cfg_rev_out = value[7];
				if (value[0])
					model_crc = cfg_init & mask_of(width_of(cfg_psize));
			end
			`CRC_INIT_OFS: cfg_init = value;
			`CRC_POL_OFS:  cfg_poly = value;
			default:       ;
		endcase
	endtask

	task automatic dr_write(input logic [1:0] size, input word_t data);
		wr_data[0] = data;
		write_burst(`CRC_DR_OFS, size, 1);
		model_write(data, size);
	endtask

	task automatic random_dr_writes(input int n);
		word_t pick;
		for (int i = 0; i < n; i++)
		begin
			pick = rand_bits(2) % 3;
			dr_write(pick[1:0], rand_bits(32));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus assertions and watchdog
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge HCLK) disable iff (!HRESETn) HRESP == 1'b0)
	else
	begin
		errors++;
		$display("ERR %0t: HRESP is not OKAY", $time);
	end

	assert property (@(posedge HCLK) disable iff (!HRESETn) !$isunknown(HREADYOUT))
	else
	begin
		errors++;
		$display("ERR %0t: HREADYOUT is unknown", $time);
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		HRESETn = 1'b0;
		HSELx = 1'b0;
		HADDR = 32'd0;
		HTRANS = HTRANS_IDLE;
		HSIZE = 3'd2;
		HWRITE = 1'b0;
		HWDATA = 32'd0;
		lfsr_q = 32'h393a83d1;
		errors = 0;
		checks = 0;
		stall_cnt = 0;
		cfg_psize = 2'b00;
		cfg_rev_in = 2'b00;
		cfg_rev_out = 1'b0;
		cfg_poly = `CRC_POLY_RST;
		cfg_init = `CRC_INIT_RST;
		model_crc = `CRC_INIT_RST;
		repeat (8) @(posedge HCLK);
		HRESETn <= 1'b1;
		@(negedge HCLK);
		expect_equal("HREADYOUT after reset", {31'd0, HREADYOUT}, 32'd1);

		// Reset values and IDR scratch byte
		bus_read(`CRC_CR_OFS, rd_val);
		expect_equal("CR after reset", rd_val, 32'd0);
		bus_read(`CRC_POL_OFS, rd_val);
		expect_equal("POL after reset", rd_val, 32'h04C1_1DB7);
		bus_read(`CRC_INIT_OFS, rd_val);
		expect_equal("INIT after reset", rd_val, 32'hFFFF_FFFF);
		bus_read(`CRC_DR_OFS, rd_val);
		expect_equal("DR after reset", rd_val, 32'hFFFF_FFFF);
		new_init = rand_bits(32);
		reg_write(`CRC_IDR_OFS, new_init);
		bus_read(`CRC_IDR_OFS, rd_val);
		expect_equal("IDR", rd_val, {24'd0, new_init[7:0]});

		// Plain CRC-32 over sixteen words
		for (int i = 0; i < 16; i++)
			dr_write(2'd2, rand_bits(32));
		bus_read(`CRC_DR_OFS, rd_val);
		expect_equal("DR default CRC-32", rd_val, expected_dr());

		// Every polynomial width with mixed transfer sizes
		for (int p = 0; p < 4; p++)
		begin
			reg_write(`CRC_POL_OFS, rand_bits(32));
			reg_write(`CRC_CR_OFS, {24'd0, 3'b000, 2'(p), 3'b001});
			random_dr_writes(12);
			bus_read(`CRC_DR_OFS, rd_val);
			expect_equal("DR per width", rd_val, expected_dr());
		end

		// Input and output reversal codes, random width
		for (int r = 0; r < 8; r++)
		begin
			rnd    = rand_bits(2);
			cr_val = {24'd0, r[0], r[2:1], rnd[1:0], 3'b001};
			reg_write(`CRC_CR_OFS, cr_val);
			random_dr_writes(8);
			bus_read(`CRC_DR_OFS, rd_val);
			expect_equal("DR with reversal", rd_val, expected_dr());
		end

		// Back-to-back words must stall on a full buffer without loss
		reg_write(`CRC_CR_OFS, 32'h0000_0001);
		for (int i = 0; i < 8; i++)
			wr_data[i] = rand_bits(32);
		stall_cnt = 0;
		write_burst(`CRC_DR_OFS, 2'd2, 8);
		for (int i = 0; i < 8; i++)
			model_write(wr_data[i], 2'd2);
		checks++;
		assert (stall_cnt > 0)
		else
		begin
			errors++;
			$display("ERR %0t: no wait state seen on back-to-back DR writes", $time);
		end
		bus_read(`CRC_DR_OFS, rd_val);
		expect_equal("DR after burst", rd_val, expected_dr());

		// Chain reset with data still buffered
		for (int i = 0; i < 4; i++)
			wr_data[i] = rand_bits(32);
		write_burst(`CRC_DR_OFS, 2'd2, 4);
		for (int i = 0; i < 4; i++)
			model_write(wr_data[i], 2'd2);
		new_init = rand_bits(32);
		reg_write(`CRC_INIT_OFS, new_init);
		rnd    = rand_bits(5);
		cr_val = {24'd0, rnd[4:0], 3'b001};
		reg_write(`CRC_CR_OFS, cr_val);
		bus_read(`CRC_DR_OFS, rd_val);
		expect_equal("DR after chain reset", rd_val, expected_dr());
		random_dr_writes(4);
		bus_read(`CRC_DR_OFS, rd_val);
		expect_equal("DR seeded from new INIT", rd_val, expected_dr());

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+src
src/crc_pkg.sv
src/crc_cfg_if.sv
src/host_interface.sv
src/data_buffer.sv
src/crc_compute.sv
src/crc_control.sv
src/crc_ahb_top.sv
tb/tb_crc_ahb.sv

// ==== Makefile ====
# Verilator build and run of the AHB CRC unit testbench

VERILATOR ?= verilator
TOP       ?= tb_crc_ahb
LINT_TOP  ?= crc_ahb_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  ?= Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
